/* verilog/biquad_pkg.sv */
// Shared widths, fixed-point types and FSM encodings, imported by every biquad design unit
`default_nettype none

package biquad_pkg;

  // ----------------------------------------
  // Word widths
  // ----------------------------------------

  // Coefficient word, also used for cos, sin, Q and alfa
  localparam int COEF_W   = 18;
  // Filter input and output samples
  localparam int SAMPLE_W = 16;
  // Partial sums of the datapath, wide enough for three products
  localparam int ACC_W    = 40;

  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // Saturation limits
  localparam coef_t   COEF_MAX   = {1'b0, {(COEF_W-1){1'b1}}};
  localparam coef_t   COEF_MIN   = {1'b1, {(COEF_W-1){1'b0}}};
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  // Filter response, code 3 behaves as band pass
  typedef enum logic [1:0] {
    low_pass_e  = 2'd0,
    high_pass_e = 2'd1,
    band_pass_e = 2'd2
  } iir_type_t;

  // Coefficient sequencer FSM
  typedef enum logic [3:0] {
    wait_q_st,
    alfa_st,
    raw_st,
    norm_b0_st,
    norm_b1_st,
    norm_b2_st,
    norm_a1_st,
    norm_a2_st,
    idle_st
  } seq_state_t;

endpackage

`default_nettype wire

/* verilog/div_if.sv */
// Request and quotient channel between the coefficient sequencer and the shared divider
`timescale 1ns/1ps
`default_nettype none

interface div_if;
  import biquad_pkg::*;

  // Request, one beat carries both operands
  logic  req_valid;
  logic  req_ready;
  coef_t dividend;
  coef_t divisor;

  // Result pulse, always accepted by the requester
  logic  res_valid;
  coef_t quotient;

  modport requester (
    output req_valid, dividend, divisor,
    input  req_ready, res_valid, quotient
  );

  modport divider (
    input  req_valid, dividend, divisor,
    output req_ready, res_valid, quotient
  );

endinterface

`default_nettype wire

/* verilog/coef_if.sv */
// Published filter coefficients, driven by the sequencer and read by the two datapath stages
`timescale 1ns/1ps
`default_nettype none

interface coef_if;
  import biquad_pkg::*;

  // Zeros
  coef_t b0;
  coef_t b1;
  coef_t b2;
  // Poles, a0 already normalized away
  coef_t a1;
  coef_t a2;

  modport source (output b0, b1, b2, a1, a2);
  modport zeros  (input  b0, b1, b2);
  modport poles  (input  a1, a2);

endinterface

`default_nettype wire

/* verilog/fixed_divider.sv */
// Shared serial signed divider, returns (dividend << COEF_Q) / divisor saturated to a coefficient
`timescale 1ns/1ps
`default_nettype none

module fixed_divider #(
  parameter int COEF_Q = 14
) (
  input  logic   clk,
  input  logic   rst_n,
  div_if.divider div
);
  import biquad_pkg::*;

  // One quotient bit per cycle over the scaled numerator
  localparam int NUM_W = COEF_W + COEF_Q;
  localparam int CNT_W = $clog2(NUM_W + 1);

  logic              run_q;
  logic              fin_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              neg_q;
  logic [COEF_W-1:0] den_q;
  logic [COEF_W-1:0] rem_q;
  logic [NUM_W-1:0]  num_q;
  logic [COEF_W-1:0] dvd_mag;
  logic [COEF_W-1:0] dvs_mag;
  logic [COEF_W:0]   rem_sh;
  logic [COEF_W+1:0] diff;
  logic              accept;
  logic              last_bit;
  logic              ovf_pos;
  logic              ovf_neg;

  // Ready only while nothing is in progress
  assign div.req_ready = ~run_q & ~fin_q;
  assign accept        = div.req_valid & div.req_ready;
  assign last_bit      = (cnt_q == CNT_W'(NUM_W - 1));

  // Operand magnitudes, the most negative value maps to 2^(COEF_W-1)
  assign dvd_mag = div.dividend[COEF_W-1] ? -div.dividend : div.dividend;
  assign dvs_mag = div.divisor[COEF_W-1]  ? -div.divisor  : div.divisor;

  // Restoring step: bring down the next numerator bit and trial subtract
  assign rem_sh = {rem_q, num_q[NUM_W-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, den_q};

  // Magnitude limits for each result sign
  assign ovf_pos = |num_q[NUM_W-1:COEF_W-1];
  assign ovf_neg = (|num_q[NUM_W-1:COEF_W]) | (num_q[COEF_W-1] & (|num_q[COEF_W-2:0]));

  // ----------------------------------------
  // Control
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q         <= 1'b0;
      fin_q         <= 1'b0;
      cnt_q         <= '0;
      div.res_valid <= 1'b0;
    end else begin
      div.res_valid <= fin_q;
      fin_q         <= run_q & last_bit;
      if (accept) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        if (last_bit) begin
          run_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      num_q <= {dvd_mag, {COEF_Q{1'b0}}};
      den_q <= dvs_mag;
      rem_q <= '0;
      neg_q <= div.dividend[COEF_W-1] ^ div.divisor[COEF_W-1];
    end else if (run_q) begin
      // Quotient bits shift in where numerator bits leave
      num_q <= {num_q[NUM_W-2:0], ~diff[COEF_W+1]};
      rem_q <= diff[COEF_W+1] ? rem_sh[COEF_W-1:0] : diff[COEF_W-1:0];
    end
    // Sign and saturate, a zero divisor yields all ones and so the limit
    if (fin_q) begin
      if (neg_q) begin
        div.quotient <= ovf_neg ? COEF_MIN : -coef_t'(num_q[COEF_W-1:0]);
      end else begin
        div.quotient <= ovf_pos ? COEF_MAX : coef_t'(num_q[COEF_W-1:0]);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/coef_sequencer.sv */
// Coefficient engine FSM, recomputes alfa and normalized biquad coefficients on configuration change
`timescale 1ns/1ps
`default_nettype none

module coef_sequencer #(
  parameter int COEF_Q = 14
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  biquad_pkg::coef_t     cfg_cos,
  input  biquad_pkg::coef_t     cfg_sin,
  input  biquad_pkg::coef_t     cfg_q,
  input  biquad_pkg::iir_type_t cfg_type,
  div_if.requester              div,
  coef_if.source                coef,
  output biquad_pkg::coef_t     alfa,
  output logic                  busy
);
  import biquad_pkg::*;

  // Unity in fixed point
  localparam coef_t ONE = coef_t'(1 << COEF_Q);

  seq_state_t state_q;
  logic       wait_res_q;
  // Configuration snapshot
  coef_t      cos_q;
  coef_t      sin_q;
  coef_t      q_q;
  iir_type_t  type_q;
  // Raw coefficients before normalization
  coef_t      raw_a0;
  coef_t      raw_b0;
  coef_t      raw_b1;
  coef_t      raw_b2;
  coef_t      raw_a1;
  coef_t      raw_a2;
  // Normalized values held until all five are ready
  coef_t      pend_b0;
  coef_t      pend_b1;
  coef_t      pend_b2;
  coef_t      pend_a1;
  coef_t      op_dividend;
  coef_t      op_divisor;
  coef_t      one_m_cos;
  coef_t      one_p_cos;
  coef_t      sin_half;
  logic       div_state;
  logic       launch;
  logic       res_take;
  logic       geom_chg;
  logic       type_chg;

  assign one_m_cos = ONE - cos_q;
  assign one_p_cos = ONE + cos_q;
  assign sin_half  = sin_q >>> 1;

  // Geometry change redoes alfa, a type change only the coefficients
  assign geom_chg = (cfg_cos != cos_q) || (cfg_sin != sin_q) || (cfg_q != q_q);
  assign type_chg = (cfg_type != type_q);

  // ----------------------------------------
  // Divider operand select
  // ----------------------------------------

  always_comb begin
    div_state  = 1'b1;
    op_divisor = raw_a0;
    case (state_q)
      alfa_st: begin
        // alfa = sin / 2Q
        op_dividend = sin_q;
        op_divisor  = q_q <<< 1;
      end
      norm_b0_st: op_dividend = raw_b0;
      norm_b1_st: op_dividend = raw_b1;
      norm_b2_st: op_dividend = raw_b2;
      norm_a1_st: op_dividend = raw_a1;
      norm_a2_st: op_dividend = raw_a2;
      default: begin
        op_dividend = raw_b0;
        div_state   = 1'b0;
      end
    endcase
  end

  // New request once per divide state, result taken while waiting
  assign launch   = div_state & ~wait_res_q & ~div.req_valid;
  assign res_take = wait_res_q & div.res_valid;

  // ----------------------------------------
  // FSM and published registers
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= wait_q_st;
      busy          <= 1'b0;
      wait_res_q    <= 1'b0;
      div.req_valid <= 1'b0;
      cos_q         <= '0;
      sin_q         <= '0;
      q_q           <= '0;
      type_q        <= low_pass_e;
      alfa          <= '0;
      // Pass-through until the first calculation
      coef.b0       <= ONE;
      coef.b1       <= '0;
      coef.b2       <= '0;
      coef.a1       <= '0;
      coef.a2       <= '0;
    end else begin
      if (launch) begin
        div.req_valid <= 1'b1;
      end
      if (div.req_valid && div.req_ready) begin
        div.req_valid <= 1'b0;
        wait_res_q    <= 1'b1;
      end
      if (res_take) begin
        wait_res_q <= 1'b0;
      end

      case (state_q)
        // Q is the last field set, so start once it is nonzero
        wait_q_st: begin
          if (cfg_q != '0) begin
            cos_q   <= cfg_cos;
            sin_q   <= cfg_sin;
            q_q     <= cfg_q;
            type_q  <= cfg_type;
            busy    <= 1'b1;
            state_q <= alfa_st;
          end
        end
        alfa_st: begin
          if (res_take) begin
            alfa    <= div.quotient;
            state_q <= raw_st;
          end
        end
        raw_st:     state_q <= norm_b0_st;
        norm_b0_st: if (res_take) state_q <= norm_b1_st;
        norm_b1_st: if (res_take) state_q <= norm_b2_st;
        norm_b2_st: if (res_take) state_q <= norm_a1_st;
        norm_a1_st: if (res_take) state_q <= norm_a2_st;
        norm_a2_st: begin
          // All five switch on the same edge as busy falls
          if (res_take) begin
            coef.b0 <= pend_b0;
            coef.b1 <= pend_b1;
            coef.b2 <= pend_b2;
            coef.a1 <= pend_a1;
            coef.a2 <= div.quotient;
            busy    <= 1'b0;
            state_q <= idle_st;
          end
        end
        idle_st: begin
          if (geom_chg) begin
            cos_q   <= cfg_cos;
            sin_q   <= cfg_sin;
            q_q     <= cfg_q;
            type_q  <= cfg_type;
            busy    <= 1'b1;
            state_q <= alfa_st;
          end else if (type_chg) begin
            type_q  <= cfg_type;
            busy    <= 1'b1;
            state_q <= raw_st;
          end
        end
        default: state_q <= wait_q_st;
      endcase
    end
  end

  // ----------------------------------------
  // Operands and intermediate coefficients
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (launch) begin
      div.dividend <= op_dividend;
      div.divisor  <= op_divisor;
    end
    if (state_q == raw_st) begin
      raw_a0 <= ONE + alfa;
      raw_a1 <= -(cos_q <<< 1);
      raw_a2 <= ONE - alfa;
      case (type_q)
        low_pass_e: begin
          raw_b0 <= one_m_cos >>> 1;
          raw_b1 <= one_m_cos;
          raw_b2 <= one_m_cos >>> 1;
        end
        high_pass_e: begin
          raw_b0 <= one_p_cos >>> 1;
          raw_b1 <= -one_p_cos;
          raw_b2 <= one_p_cos >>> 1;
        end
        // Band pass, also any unknown code
        default: begin
          raw_b0 <= sin_half;
          raw_b1 <= '0;
          raw_b2 <= -sin_half;
        end
      endcase
    end
    if (res_take) begin
      case (state_q)
        norm_b0_st: pend_b0 <= div.quotient;
        norm_b1_st: pend_b1 <= div.quotient;
        norm_b2_st: pend_b2 <= div.quotient;
        norm_a1_st: pend_a1 <= div.quotient;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/feedforward_stage.sv */
// First biquad pipeline stage, forms the zero sum b0*x + b1*x1 + b2*x2 per accepted sample
`timescale 1ns/1ps
`default_nettype none

module feedforward_stage #(
  parameter int COEF_Q = 14
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                x_valid,
  input  biquad_pkg::sample_t x,
  coef_if.zeros               coef,
  output logic                ff_valid,
  output biquad_pkg::acc_t    ff_sum
);
  import biquad_pkg::*;

  // Input history
  sample_t x1_q;
  sample_t x2_q;
  acc_t    prod_b0;
  acc_t    prod_b1;
  acc_t    prod_b2;

  // Outside this range the Q-format sum loses headroom in acc_t
  if (COEF_Q < 12 || COEF_Q > 16) begin : g_q_range
    $error("COEF_Q must lie between 12 and 16");
  end

  // Products stay in Q(COEF_Q), scaling happens in the feedback stage
  assign prod_b0 = acc_t'(coef.b0) * acc_t'(x);
  assign prod_b1 = acc_t'(coef.b1) * acc_t'(x1_q);
  assign prod_b2 = acc_t'(coef.b2) * acc_t'(x2_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ff_valid <= 1'b0;
      x1_q     <= '0;
      x2_q     <= '0;
    end else begin
      ff_valid <= x_valid;
      if (x_valid) begin
        x1_q <= x;
        x2_q <= x1_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x_valid) begin
      ff_sum <= prod_b0 + prod_b1 + prod_b2;
    end
  end

endmodule

`default_nettype wire

/* verilog/feedback_stage.sv */
// Second biquad pipeline stage, subtracts the pole sum, rescales and saturates to the output sample
`timescale 1ns/1ps
`default_nettype none

module feedback_stage #(
  parameter int COEF_Q = 14
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ff_valid,
  input  biquad_pkg::acc_t    ff_sum,
  coef_if.poles               coef,
  output logic                y_valid,
  output biquad_pkg::sample_t y
);
  import biquad_pkg::*;

  // y doubles as y1, y2_q is the older output
  sample_t y2_q;
  acc_t    pole_sum;
  acc_t    acc;
  acc_t    scaled;
  sample_t y_sat;

  assign pole_sum = acc_t'(coef.a1) * acc_t'(y) + acc_t'(coef.a2) * acc_t'(y2_q);
  assign acc      = ff_sum - pole_sum;
  // Back from Q(COEF_Q) to sample scale
  assign scaled   = acc >>> COEF_Q;

  // ----------------------------------------
  // Output saturation
  // ----------------------------------------

  always_comb begin
    if (scaled > acc_t'(SAMPLE_MAX)) begin
      y_sat = SAMPLE_MAX;
    end else if (scaled < acc_t'(SAMPLE_MIN)) begin
      y_sat = SAMPLE_MIN;
    end else begin
      y_sat = sample_t'(scaled);
    end
  end

  // Output register, feeds the recursion in the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_valid <= 1'b0;
      y       <= '0;
      y2_q    <= '0;
    end else begin
      y_valid <= ff_valid;
      if (ff_valid) begin
        y    <= y_sat;
        y2_q <= y;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/biquad_top.sv */
// Biquad IIR filter top, joins coefficient engine, shared divider and the two-stage datapath
`timescale 1ns/1ps
`default_nettype none

module biquad_top #(
  parameter int COEF_Q = 14
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Configuration levels
  input  biquad_pkg::coef_t     cfg_cos,
  input  biquad_pkg::coef_t     cfg_sin,
  input  biquad_pkg::coef_t     cfg_q,
  input  biquad_pkg::iir_type_t cfg_type,
  // Sample stream
  input  logic                  x_valid,
  input  biquad_pkg::sample_t   x,
  output logic                  y_valid,
  output biquad_pkg::sample_t   y,
  // Status
  output logic                  busy,
  output biquad_pkg::coef_t     sr_alfa,
  output biquad_pkg::coef_t     sr_b0,
  output biquad_pkg::coef_t     sr_b1,
  output biquad_pkg::coef_t     sr_b2,
  output biquad_pkg::coef_t     sr_a1,
  output biquad_pkg::coef_t     sr_a2
);

  biquad_pkg::acc_t ff_sum;
  logic             ff_valid;

  div_if  div_bus ();
  coef_if coef_bus ();

  // ----------------------------------------
  // Coefficient engine
  // ----------------------------------------

  coef_sequencer #(
    .COEF_Q (COEF_Q)
  ) i_coef_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_cos  (cfg_cos),
    .cfg_sin  (cfg_sin),
    .cfg_q    (cfg_q),
    .cfg_type (cfg_type),
    .div      (div_bus.requester),
    .coef     (coef_bus.source),
    .alfa     (sr_alfa),
    .busy     (busy)
  );

  fixed_divider #(
    .COEF_Q (COEF_Q)
  ) i_fixed_divider (
    .clk   (clk),
    .rst_n (rst_n),
    .div   (div_bus.divider)
  );

  // ----------------------------------------
  // Filter datapath
  // ----------------------------------------

  feedforward_stage #(
    .COEF_Q (COEF_Q)
  ) i_feedforward_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .x_valid  (x_valid),
    .x        (x),
    .coef     (coef_bus.zeros),
    .ff_valid (ff_valid),
    .ff_sum   (ff_sum)
  );

  feedback_stage #(
    .COEF_Q (COEF_Q)
  ) i_feedback_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .ff_valid (ff_valid),
    .ff_sum   (ff_sum),
    .coef     (coef_bus.poles),
    .y_valid  (y_valid),
    .y        (y)
  );

  // Published coefficients as status
  assign sr_b0 = coef_bus.b0;
  assign sr_b1 = coef_bus.b1;
  assign sr_b2 = coef_bus.b2;
  assign sr_a1 = coef_bus.a1;
  assign sr_a2 = coef_bus.a2;

endmodule

`default_nettype wire

/* dv/biquad_chk.sv */
// Assertions on reset levels, output latency and the divider handshake, bound into biquad_top
`timescale 1ns/1ps
`default_nettype none

module biquad_chk (
  input logic clk,
  input logic rst_n,
  input logic busy,
  input logic x_valid,
  input logic y_valid,
  input logic div_req_valid,
  input logic div_req_ready,
  input logic div_res_valid
);

  // Set from accept until the quotient pulse
  logic div_active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_active <= 1'b0;
    end else if (div_req_valid && div_req_ready) begin
      div_active <= 1'b1;
    end else if (div_res_valid) begin
      div_active <= 1'b0;
    end
  end

  // ----------------------------------------
  // Reset
  // ----------------------------------------

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !busy && !y_valid)
    else $error("busy or y_valid high during reset");

  // First edge out of reset must not start anything
  release_quiet: assert property (@(posedge clk) $rose(rst_n) |=> !busy && !y_valid)
    else $error("busy or y_valid high right after reset");

  // ----------------------------------------
  // Datapath and divider
  // ----------------------------------------

  y_latency: assert property (@(posedge clk) disable iff (!rst_n)
    y_valid == $past(x_valid, 2))
    else $error("y_valid does not follow x_valid by two cycles");

  div_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
    div_active && !div_res_valid |-> !div_req_ready)
    else $error("Divider ready while a division runs");

endmodule

bind biquad_top biquad_chk i_biquad_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .busy          (busy),
  .x_valid       (x_valid),
  .y_valid       (y_valid),
  .div_req_valid (div_bus.req_valid),
  .div_req_ready (div_bus.req_ready),
  .div_res_valid (div_bus.res_valid)
);

`default_nettype wire

/* dv/tb_biquad.sv */
// Testbench for biquad_top, replays the pattern file and checks coefficients and filter output
`timescale 1ns/1ps
`default_nettype none

module tb_biquad;
  import biquad_pkg::*;

  localparam int COEF_Q   = 14;
  localparam int ONE_Q    = 1 << COEF_Q;
  localparam int MAX_PAT  = 32;
  localparam int BURST    = 24;
  // Pattern used for the saturation run, peak gain of two
  localparam int SAT_PAT  = 6;
  // Divider latency plus handshake slack
  localparam int DIV_CYC  = COEF_W + COEF_Q + 1 + 8;
  localparam int Y_MAX    = (1 << (SAMPLE_W - 1)) - 1;
  localparam int Y_MIN    = -(1 << (SAMPLE_W - 1));
  localparam string PAT_FILE = "dv/biquad_patterns.txt";

  logic      clk;
  logic      rst_n;
  coef_t     cfg_cos;
  coef_t     cfg_sin;
  coef_t     cfg_q;
  iir_type_t cfg_type;
  logic      x_valid;
  sample_t   x;
  logic      y_valid;
  sample_t   y;
  logic      busy;
  coef_t     sr_alfa;
  coef_t     sr_b0;
  coef_t     sr_b1;
  coef_t     sr_b2;
  coef_t     sr_a1;
  coef_t     sr_a2;

  // Columns: cos sin q type alfa b0 b1 b2 a1 a2
  int pat [MAX_PAT][10];
  int n_pat;
  int n_checks;
  int n_errs;
  int n_sat;
  int cyc;
  int wd_limit;
  // Reference filter state and current coefficients b0 b1 b2 a1 a2
  int exp_coef [5];
  int mx1;
  int mx2;
  int my1;
  int my2;
  int exp_y [$];
  int exp_cyc [$];

  biquad_top #(
    .COEF_Q (COEF_Q)
  ) i_biquad_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_cos  (cfg_cos),
    .cfg_sin  (cfg_sin),
    .cfg_q    (cfg_q),
    .cfg_type (cfg_type),
    .x_valid  (x_valid),
    .x        (x),
    .y_valid  (y_valid),
    .y        (y),
    .busy     (busy),
    .sr_alfa  (sr_alfa),
    .sr_b0    (sr_b0),
    .sr_b1    (sr_b1),
    .sr_b2    (sr_b2),
    .sr_a1    (sr_a1),
    .sr_a2    (sr_a2)
  );

  // ----------------------------------------
  // Clock, cycle count, watchdog
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    wait (wd_limit != 0);
    repeat (wd_limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", wd_limit);
    $display("Checks: %0d, errors: %0d", n_checks, n_errs + 1);
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic compare(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errs++;
      $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_patterns();
    int    fd;
    int    f [10];
    string line;
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file %s", PAT_FILE);
    end else begin
      while (!$feof(fd) && n_pat < MAX_PAT) begin
        // Comment and blank lines do not parse as ten numbers
        if ($fgets(line, fd) != 0 &&
            $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4],
                    f[5], f[6], f[7], f[8], f[9]) == 10) begin
          for (int c = 0; c < 10; c++) begin
            pat[n_pat][c] = f[c];
          end
          n_pat++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Direct Form I step with Q shift and output saturation
  function automatic int model_step(input int xin);
    longint acc;
    longint scaled;
    int     yout;
    acc = longint'(exp_coef[0]) * xin + longint'(exp_coef[1]) * mx1
        + longint'(exp_coef[2]) * mx2 - longint'(exp_coef[3]) * my1
        - longint'(exp_coef[4]) * my2;
    scaled = acc >>> COEF_Q;
    if (scaled > Y_MAX) begin
      yout = Y_MAX;
    end else if (scaled < Y_MIN) begin
      yout = Y_MIN;
    end else begin
      yout = int'(scaled);
    end
    mx2 = mx1;
    mx1 = xin;
    my2 = my1;
    my1 = yout;
    return yout;
  endfunction

  task automatic send_sample(input int value);
    @(posedge clk);
    #10;
    x_valid = 1'b1;
    x       = sample_t'(value);
    exp_y.push_back(model_step(value));
    exp_cyc.push_back(cyc);
  endtask

  // Close the burst and wait until every sample has come back
  task automatic drain();
    @(posedge clk);
    #10;
    x_valid = 1'b0;
    while (exp_y.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic random_burst(input int len);
    for (int i = 0; i < len; i++) begin
      send_sample(sample_t'($urandom));
    end
    drain();
  endtask

  task automatic apply_pattern(input int idx);
    int   prev_alfa;
    int   busy_cyc;
    logic same_geom;
    prev_alfa = sr_alfa;
    same_geom = (cfg_cos == pat[idx][0]) && (cfg_sin == pat[idx][1]) && (cfg_q == pat[idx][2]);
    @(posedge clk);
    #10;
    cfg_cos  = coef_t'(pat[idx][0]);
    cfg_sin  = coef_t'(pat[idx][1]);
    cfg_q    = coef_t'(pat[idx][2]);
    cfg_type = iir_type_t'(pat[idx][3]);
    // busy rises in the cycle after the edge that sees the change
    repeat (2) @(negedge clk);
    compare("busy", busy, 1);
    busy_cyc = 0;
    while (busy) begin
      @(negedge clk);
      busy_cyc++;
    end
    compare("sr_alfa", sr_alfa, pat[idx][4]);
    compare("sr_b0", sr_b0, pat[idx][5]);
    compare("sr_b1", sr_b1, pat[idx][6]);
    compare("sr_b2", sr_b2, pat[idx][7]);
    compare("sr_a1", sr_a1, pat[idx][8]);
    compare("sr_a2", sr_a2, pat[idx][9]);
    // Type-only change keeps alfa and needs five divisions, not six
    if (same_geom) begin
      compare("sr_alfa held", sr_alfa, prev_alfa);
      if (busy_cyc >= 6 * (COEF_W + COEF_Q + 1)) begin
        n_errs++;
        $display("Type-only change kept busy for %0d cycles, alfa was divided again",
                 busy_cyc);
      end
    end
    for (int c = 0; c < 5; c++) begin
      exp_coef[c] = pat[idx][c + 5];
    end
    // No samples right after a publish
    repeat (2) @(negedge clk);
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  initial begin
    forever begin
      @(negedge clk);
      if (y_valid) begin
        if (exp_y.size() == 0) begin
          n_errs++;
          $display("Output valid in cycle %0d with no sample in flight", cyc);
        end else begin
          compare("y", y, exp_y.pop_front());
          compare("y_valid latency", cyc - exp_cyc.pop_front(), 2);
          if (y == sample_t'(Y_MAX) || y == sample_t'(Y_MIN)) begin
            n_sat++;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    rst_n    = 1'b0;
    cfg_cos  = '0;
    cfg_sin  = '0;
    cfg_q    = '0;
    cfg_type = low_pass_e;
    x_valid  = 1'b0;
    x        = '0;
    cyc      = 0;
    void'($urandom(32'he913));
    load_patterns();
    wd_limit = (n_pat + 1) * (6 * DIV_CYC + 40) + (n_pat + 3) * (BURST + 20) + 200;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;

    if (n_pat <= SAT_PAT) begin
      n_errs++;
      $display("Pattern file holds %0d patterns, too few for the saturation run", n_pat);
    end else begin
      // Pass-through while Q is still zero
      repeat (4) begin
        @(negedge clk);
        compare("busy", busy, 0);
      end
      compare("sr_b0", sr_b0, ONE_Q);
      compare("sr_b1", sr_b1, 0);
      compare("sr_b2", sr_b2, 0);
      compare("sr_a1", sr_a1, 0);
      compare("sr_a2", sr_a2, 0);
      exp_coef = '{ONE_Q, 0, 0, 0, 0};
      random_burst(16);

      // Every pattern, then a random burst with its coefficients
      for (int i = 0; i < n_pat; i++) begin
        apply_pattern(i);
        random_burst(BURST);
      end

      // Tone at the resonance drives the output into the limits
      apply_pattern(SAT_PAT);
      n_sat = 0;
      for (int i = 0; i < 48; i++) begin
        case (i % 4)
          0:       send_sample(30000);
          2:       send_sample(-30000);
          default: send_sample(0);
        endcase
      end
      drain();
      if (n_sat == 0) begin
        n_errs++;
        $display("The high-gain run never reached the output limits");
      end
    end

    $display("Checks: %0d, errors: %0d", n_checks, n_errs);
    if (n_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/biquad_patterns.txt */
# cos sin q type alfa b0 b1 b2 a1 a2, signed decimal in Q14 where 16384 is one
# type 0 low pass, 1 high pass, 2 band pass, expected values truncated toward zero
# w0 90 deg, Q 1, three types on one geometry
0 16384 16384 0 8192 5461 10922 5461 0 5461
0 16384 16384 1 8192 5461 -10922 5461 0 5461
0 16384 16384 2 8192 5461 0 -5461 0 5461
# w0 60 deg, Q 0.5
8192 14189 8192 0 14189 2195 4390 2195 -8780 1176
8192 14189 8192 1 14189 6585 -13170 6585 -8780 1176
8192 14189 8192 2 14189 3801 0 -3801 -8780 1176
# w0 90 deg, Q 2, peak gain two for the saturation run
0 16384 32768 0 4096 6553 13107 6553 0 9830
# w0 120 deg, Q 0.707
-8192 14189 11585 1 10033 2540 -5080 2540 10161 3938

/* src.f */
verilog/biquad_pkg.sv
verilog/div_if.sv
verilog/coef_if.sv
verilog/fixed_divider.sv
verilog/coef_sequencer.sv
verilog/feedforward_stage.sv
verilog/feedback_stage.sv
verilog/biquad_top.sv
dv/biquad_chk.sv
dv/tb_biquad.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_biquad
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PATTERNS  := dv/biquad_patterns.txt
FAIL_MSG  := Something failed
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# An aborted run counts as a failure
run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
